// ==== gemm.f ====
+incdir+.
gemm_pkg.sv
gemm_csr_file.sv
gemm_sequencer.sv
gemm_fetch_unit.sv
gemm_store_unit.sv
mem_arbiter.sv
gemm_top.sv
gemm_assert.sv
tb_gemm_top.sv

// ==== gemm_assert.sv ====
/*
  Concurrent checks on the GEMM top-level ports, bound into gemm_top.
*/
`timescale 1ns/1ns
`include "gemm_settings.svh"

module gemm_assert (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    mem_req_o,
  input logic                    mem_we_o,
  input logic [`GEMM_ADDR_W-1:0] mem_addr_o,
  input logic [`GEMM_DATA_W-1:0] mem_wdata_o,
  input logic                    mem_gnt_i,
  input logic                    csr_pvalid_o,
  input logic [`GEMM_DATA_W-1:0] csr_rdata_o,
  input logic                    csr_pready_i
);

  // a memory request holds until granted
  a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) &&
      $stable(mem_addr_o) && $stable(mem_wdata_o))
    else $error("memory request changed before its grant");

  // read response holds until the host takes it
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_pvalid_o && !csr_pready_i |=> csr_pvalid_o && $stable(csr_rdata_o))
    else $error("CSR read response changed before pready");

  a_reset_idle: assert property (@(posedge clk_i) !rst_ni |-> !mem_req_o)
    else $error("memory request raised during reset");

endmodule

bind gemm_top gemm_assert u_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .mem_req_o    (mem_req_o),
  .mem_we_o     (mem_we_o),
  .mem_addr_o   (mem_addr_o),
  .mem_wdata_o  (mem_wdata_o),
  .mem_gnt_i    (mem_gnt_i),
  .csr_pvalid_o (csr_pvalid_o),
  .csr_rdata_o  (csr_rdata_o),
  .csr_pready_i (csr_pready_i)
);

// ==== gemm_csr_file.sv ====
/*
  Host CSR block: size and base registers, idle bit, registered read response
  held until accepted, and the start pulse for the sequencer.
*/
`timescale 1ns/1ns
`include "gemm_settings.svh"

module gemm_csr_file (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        csr_qvalid_i,
  input  logic                        csr_write_i,
  input  logic [`GEMM_CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`GEMM_DATA_W-1:0]     csr_wdata_i,
  output logic                        csr_qready_o,
  output logic [`GEMM_DATA_W-1:0]     csr_rdata_o,
  output logic                        csr_pvalid_o,
  input  logic                        csr_pready_i,
  input  logic                        busy_i,
  input  logic [`GEMM_DATA_W-1:0]     perf_count_i,
  output gemm_pkg::csr_word_u         size_o,
  output logic [`GEMM_ADDR_W-1:0]     addr_a_o,
  output logic [`GEMM_ADDR_W-1:0]     addr_b_o,
  output logic [`GEMM_ADDR_W-1:0]     addr_c_o,
  output logic                        start_o
);

  logic [`GEMM_CSR_ADDR_W-1:0] offs;
  gemm_pkg::csr_word_u         size_q;
  logic [`GEMM_ADDR_W-1:0]     addr_a_q;
  logic [`GEMM_ADDR_W-1:0]     addr_b_q;
  logic [`GEMM_ADDR_W-1:0]     addr_c_q;
  logic                        busy_q;
  logic                        busy_edge;
  logic                        idle_q;
  logic                        idle_d;
  logic                        wr_acc;
  logic                        rd_acc;
  logic                        pvalid_q;
  logic [`GEMM_DATA_W-1:0]     rdata_d;
  logic [`GEMM_DATA_W-1:0]     rdata_q;

  assign offs      = csr_addr_i - `GEMM_CSR_BASE;
  assign busy_edge = busy_q != busy_i;

  // no new request while a response waits, and a state write waits out a busy edge
  assign csr_qready_o = !pvalid_q &&
      !(csr_qvalid_i && csr_write_i && offs == `GEMM_CSR_STATE && busy_edge);
  assign wr_acc  = csr_qvalid_i && csr_qready_o && csr_write_i;
  assign rd_acc  = csr_qvalid_i && csr_qready_o && !csr_write_i;
  assign start_o = wr_acc && offs == `GEMM_CSR_STATE &&
      csr_wdata_i[`GEMM_STATE_START_BIT];

  // idle follows the busy edges, read through idle_d so a poll sees the edge at once
  assign idle_d = busy_edge ? !busy_i : idle_q;

  // ----------------------------------------
  // read path
  // ----------------------------------------
  always_comb begin
    rdata_d = '0;
    case (offs)
      `GEMM_CSR_SIZE:   rdata_d = size_q.raw;
      `GEMM_CSR_ADDR_A: rdata_d[`GEMM_ADDR_W-1:0] = addr_a_q;
      `GEMM_CSR_ADDR_B: rdata_d[`GEMM_ADDR_W-1:0] = addr_b_q;
      `GEMM_CSR_ADDR_C: rdata_d[`GEMM_ADDR_W-1:0] = addr_c_q;
      `GEMM_CSR_PERF:   rdata_d = perf_count_i;
      `GEMM_CSR_STATE:  rdata_d[`GEMM_STATE_IDLE_BIT] = idle_d;
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rdata_q <= rdata_d;
    end
  end

  // ----------------------------------------
  // registers and response handshake
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      size_q   <= '0;
      addr_a_q <= '0;
      addr_b_q <= '0;
      addr_c_q <= '0;
      busy_q   <= 1'b0;
      idle_q   <= 1'b1;
      pvalid_q <= 1'b0;
    end else begin
      busy_q <= busy_i;
      idle_q <= idle_d;
      if (rd_acc) begin
        pvalid_q <= 1'b1;
      end else if (csr_pready_i) begin
        pvalid_q <= 1'b0;
      end
      // perf and state are read-only here, start is taken from the request itself
      if (wr_acc) begin
        case (offs)
          `GEMM_CSR_SIZE:   size_q.raw <= csr_wdata_i;
          `GEMM_CSR_ADDR_A: addr_a_q <= csr_wdata_i[`GEMM_ADDR_W-1:0];
          `GEMM_CSR_ADDR_B: addr_b_q <= csr_wdata_i[`GEMM_ADDR_W-1:0];
          `GEMM_CSR_ADDR_C: addr_c_q <= csr_wdata_i[`GEMM_ADDR_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign csr_pvalid_o = pvalid_q;
  assign csr_rdata_o  = rdata_q;
  assign size_o       = size_q;
  assign addr_a_o     = addr_a_q;
  assign addr_b_o     = addr_b_q;
  assign addr_c_o     = addr_c_q;

endmodule

// ==== gemm_fetch_unit.sv ====
/*
  Operand fetch: reads A then B for one step over the shared port and pairs
  the in-order responses into one op_valid pulse.
*/
`timescale 1ns/1ns
`include "gemm_settings.svh"

module gemm_fetch_unit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_start_i,
  input  logic [`GEMM_ADDR_W-1:0] addr_a_i,
  input  logic [`GEMM_ADDR_W-1:0] addr_b_i,
  output logic                    rd_req_o,
  output logic [`GEMM_ADDR_W-1:0] rd_addr_o,
  input  logic                    rd_gnt_i,
  input  logic                    rvalid_i,
  input  logic [`GEMM_DATA_W-1:0] rdata_i,
  output logic                    op_valid_o,
  output gemm_pkg::elem_t         op_a_o,
  output gemm_pkg::elem_t         op_b_o
);

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_A    = 2'd1;
  localparam logic [1:0] PH_B    = 2'd2;

  logic [1:0]              phase_q;
  logic [`GEMM_ADDR_W-1:0] addr_a_q;
  logic [`GEMM_ADDR_W-1:0] addr_b_q;
  logic                    got_a_q;
  logic                    op_valid_q;
  gemm_pkg::elem_t         a_q;
  gemm_pkg::elem_t         b_q;

  assign rd_req_o  = phase_q != PH_IDLE;
  assign rd_addr_o = (phase_q == PH_B) ? addr_b_q : addr_a_q;

  // request side, A goes out first so the first response is always A
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q    <= PH_IDLE;
      got_a_q    <= 1'b0;
      op_valid_q <= 1'b0;
    end else begin
      if (fetch_start_i) begin
        phase_q <= PH_A;
      end else if (rd_gnt_i) begin
        phase_q <= (phase_q == PH_A) ? PH_B : PH_IDLE;
      end
      // second response completes the pair
      op_valid_q <= rvalid_i && got_a_q;
      if (rvalid_i) begin
        got_a_q <= !got_a_q;
      end
    end
  end

  // capture responses as they arrive, A may come back before B is even granted
  always_ff @(posedge clk_i) begin
    if (fetch_start_i) begin
      addr_a_q <= addr_a_i;
      addr_b_q <= addr_b_i;
    end
    if (rvalid_i && !got_a_q) begin
      a_q <= gemm_pkg::elem_t'(rdata_i[`GEMM_ELEM_W-1:0]);
    end
    if (rvalid_i && got_a_q) begin
      b_q <= gemm_pkg::elem_t'(rdata_i[`GEMM_ELEM_W-1:0]);
    end
  end

  assign op_valid_o = op_valid_q;
  assign op_a_o     = a_q;
  assign op_b_o     = b_q;

endmodule

// ==== gemm_pkg.sv ====
/*
  Element, accumulator and CSR word types of the GEMM accelerator.
  Modules refer to them by scoped names.
*/
`include "gemm_settings.svh"

package gemm_pkg;

  // one matrix element, held in the low half of a memory word
  typedef logic signed [`GEMM_ELEM_W-1:0] elem_t;

  // running sum, also the C word written back
  typedef logic signed [`GEMM_DATA_W-1:0] acc_t;

  // size register layout, only the low GEMM_DIM_W bits of each byte count
  typedef struct packed {
    logic [7:0] rsvd;
    logic [7:0] m;
    logic [7:0] k;
    logic [7:0] n;
  } mat_size_t;

  // raw for the CSR access path, size where the loops decode it
  typedef union packed {
    logic [`GEMM_DATA_W-1:0] raw;
    mat_size_t               size;
  } csr_word_u;

endpackage

// ==== gemm_sequencer.sv ====
/*
  Loop control of the GEMM job: steps i, j and k, requests each operand pair,
  accumulates it and hands every finished C word to the store unit.
*/
`timescale 1ns/1ns
`include "gemm_settings.svh"

module gemm_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  gemm_pkg::csr_word_u     size_i,
  input  logic [`GEMM_ADDR_W-1:0] addr_a_i,
  input  logic [`GEMM_ADDR_W-1:0] addr_b_i,
  input  logic [`GEMM_ADDR_W-1:0] addr_c_i,
  output logic                    fetch_start_o,
  output logic [`GEMM_ADDR_W-1:0] fetch_addr_a_o,
  output logic [`GEMM_ADDR_W-1:0] fetch_addr_b_o,
  input  logic                    op_valid_i,
  input  gemm_pkg::elem_t         op_a_i,
  input  gemm_pkg::elem_t         op_b_i,
  output logic                    st_valid_o,
  output logic [`GEMM_ADDR_W-1:0] st_addr_o,
  output gemm_pkg::acc_t          st_data_o,
  input  logic                    st_ready_i,
  output logic                    busy_o,
  output logic [`GEMM_DATA_W-1:0] perf_count_o
);

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_ISSUE = 3'd1;
  localparam logic [2:0] ST_WAIT  = 3'd2;
  localparam logic [2:0] ST_STORE = 3'd3;
  localparam logic [2:0] ST_DRAIN = 3'd4;

  logic [2:0]              state_q;
  logic [`GEMM_DIM_W-1:0]  dim_m;
  logic [`GEMM_DIM_W-1:0]  dim_k;
  logic [`GEMM_DIM_W-1:0]  dim_n;
  logic [`GEMM_DIM_W-1:0]  i_q;
  logic [`GEMM_DIM_W-1:0]  j_q;
  logic [`GEMM_DIM_W-1:0]  k_q;
  logic                    last_i;
  logic                    last_j;
  logic                    last_k;
  logic                    dims_ok;
  gemm_pkg::acc_t          acc_q;
  gemm_pkg::acc_t          acc_d;
  logic [`GEMM_DATA_W-1:0] perf_q;

  assign dim_m   = size_i.size.m[`GEMM_DIM_W-1:0];
  assign dim_k   = size_i.size.k[`GEMM_DIM_W-1:0];
  assign dim_n   = size_i.size.n[`GEMM_DIM_W-1:0];
  assign dims_ok = dim_m != '0 && dim_k != '0 && dim_n != '0;
  assign last_i  = i_q == dim_m - `GEMM_DIM_W'(1);
  assign last_j  = j_q == dim_n - `GEMM_DIM_W'(1);
  assign last_k  = k_q == dim_k - `GEMM_DIM_W'(1);

  // dense row-major addressing
  assign fetch_addr_a_o = addr_a_i + `GEMM_ADDR_W'(i_q) * `GEMM_ADDR_W'(dim_k) +
      `GEMM_ADDR_W'(k_q);
  assign fetch_addr_b_o = addr_b_i + `GEMM_ADDR_W'(k_q) * `GEMM_ADDR_W'(dim_n) +
      `GEMM_ADDR_W'(j_q);
  assign st_addr_o = addr_c_i + `GEMM_ADDR_W'(i_q) * `GEMM_ADDR_W'(dim_n) +
      `GEMM_ADDR_W'(j_q);

  // sign-extend both elements before the product
  assign acc_d = acc_q + gemm_pkg::acc_t'(op_a_i) * gemm_pkg::acc_t'(op_b_i);

  assign fetch_start_o = state_q == ST_ISSUE;
  assign st_valid_o    = state_q == ST_STORE && st_ready_i;
  assign st_data_o     = acc_q;
  assign busy_o        = state_q != ST_IDLE;
  assign perf_count_o  = perf_q;

  // ----------------------------------------
  // loop FSM and performance counter
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      i_q     <= '0;
      j_q     <= '0;
      k_q     <= '0;
      perf_q  <= '0;
    end else begin
      if (busy_o) begin
        perf_q <= perf_q + `GEMM_DATA_W'(1);
      end
      case (state_q)
        ST_IDLE: begin
          // starts with an empty dimension never leave idle
          if (start_i && dims_ok) begin
            state_q <= ST_ISSUE;
            i_q     <= '0;
            j_q     <= '0;
            k_q     <= '0;
            perf_q  <= '0;
          end
        end
        ST_ISSUE: state_q <= ST_WAIT;
        ST_WAIT: begin
          if (op_valid_i) begin
            if (last_k) begin
              state_q <= ST_STORE;
            end else begin
              k_q     <= k_q + `GEMM_DIM_W'(1);
              state_q <= ST_ISSUE;
            end
          end
        end
        ST_STORE: begin
          // result waits here until the store unit has room
          if (st_ready_i) begin
            k_q     <= '0;
            state_q <= ST_ISSUE;
            if (!last_j) begin
              j_q <= j_q + `GEMM_DIM_W'(1);
            end else begin
              j_q <= '0;
              if (last_i) begin
                state_q <= ST_DRAIN;
              end else begin
                i_q <= i_q + `GEMM_DIM_W'(1);
              end
            end
          end
        end
        // last word is in the store unit, done once it is granted
        ST_DRAIN: begin
          if (st_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE || st_valid_o) begin
      acc_q <= '0;
    end else if (state_q == ST_WAIT && op_valid_i) begin
      acc_q <= acc_d;
    end
  end

endmodule

// ==== gemm_settings.svh ====
/*
  Widths, limits and the CSR map of the GEMM accelerator.
  Included by the package and by every module that needs a width or an address.
*/
`ifndef GEMM_SETTINGS_SVH
`define GEMM_SETTINGS_SVH

// datapath and memory widths
`define GEMM_DATA_W 32
`define GEMM_ADDR_W 16
`define GEMM_ELEM_W 16
// low bits used of each size byte, so a dimension is at most 15
`define GEMM_DIM_W 4

// ----------------------------------------
// CSR map, offsets relative to the base
// ----------------------------------------
`define GEMM_CSR_ADDR_W 12
`define GEMM_CSR_BASE   12'h3c0
`define GEMM_CSR_SIZE   12'd0
`define GEMM_CSR_ADDR_A 12'd1
`define GEMM_CSR_ADDR_B 12'd2
`define GEMM_CSR_ADDR_C 12'd3
`define GEMM_CSR_PERF   12'd4
`define GEMM_CSR_STATE  12'd5

// state register bits
`define GEMM_STATE_START_BIT 0
`define GEMM_STATE_IDLE_BIT  1

`endif

// ==== gemm_store_unit.sv ====
/*
  One-entry store buffer for C words; keeps its write request up until
  the arbiter grants it, so the next fetch can run meanwhile.
*/
`timescale 1ns/1ns
`include "gemm_settings.svh"

module gemm_store_unit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    st_valid_i,
  input  logic [`GEMM_ADDR_W-1:0] st_addr_i,
  input  gemm_pkg::acc_t          st_data_i,
  output logic                    st_ready_o,
  output logic                    wr_req_o,
  output logic [`GEMM_ADDR_W-1:0] wr_addr_o,
  output logic [`GEMM_DATA_W-1:0] wr_data_o,
  input  logic                    wr_gnt_i
);

  logic                    full_q;
  logic [`GEMM_ADDR_W-1:0] addr_q;
  gemm_pkg::acc_t          data_q;

  // room when empty, or when the held word leaves this cycle
  assign st_ready_o = !full_q || wr_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (st_valid_i && st_ready_o) begin
      full_q <= 1'b1;
    end else if (wr_gnt_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_valid_i && st_ready_o) begin
      addr_q <= st_addr_i;
      data_q <= st_data_i;
    end
  end

  assign wr_req_o  = full_q;
  assign wr_addr_o = addr_q;
  assign wr_data_o = data_q;

endmodule

// ==== gemm_top.sv ====
/*
  Top level of the GEMM accelerator: CSR block, sequencer, fetch and store
  units, and the arbiter in front of the shared memory port.
*/
`timescale 1ns/1ns
`include "gemm_settings.svh"

module gemm_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        csr_qvalid_i,
  input  logic                        csr_write_i,
  input  logic [`GEMM_CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`GEMM_DATA_W-1:0]     csr_wdata_i,
  output logic                        csr_qready_o,
  output logic [`GEMM_DATA_W-1:0]     csr_rdata_o,
  output logic                        csr_pvalid_o,
  input  logic                        csr_pready_i,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [`GEMM_ADDR_W-1:0]     mem_addr_o,
  output logic [`GEMM_DATA_W-1:0]     mem_wdata_o,
  input  logic                        mem_gnt_i,
  input  logic                        mem_rvalid_i,
  input  logic [`GEMM_DATA_W-1:0]     mem_rdata_i
);

  // configuration and control
  gemm_pkg::csr_word_u     size;
  logic [`GEMM_ADDR_W-1:0] addr_a;
  logic [`GEMM_ADDR_W-1:0] addr_b;
  logic [`GEMM_ADDR_W-1:0] addr_c;
  logic                    start;
  logic                    busy;
  logic [`GEMM_DATA_W-1:0] perf_count;

  // operand path
  logic                    fetch_start;
  logic [`GEMM_ADDR_W-1:0] fetch_addr_a;
  logic [`GEMM_ADDR_W-1:0] fetch_addr_b;
  logic                    op_valid;
  gemm_pkg::elem_t         op_a;
  gemm_pkg::elem_t         op_b;

  // result path
  logic                    st_valid;
  logic [`GEMM_ADDR_W-1:0] st_addr;
  gemm_pkg::acc_t          st_data;
  logic                    st_ready;

  // arbiter side
  logic                    rd_req;
  logic [`GEMM_ADDR_W-1:0] rd_addr;
  logic                    rd_gnt;
  logic                    wr_req;
  logic [`GEMM_ADDR_W-1:0] wr_addr;
  logic [`GEMM_DATA_W-1:0] wr_data;
  logic                    wr_gnt;

  gemm_csr_file u_csr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_qvalid_i (csr_qvalid_i),
    .csr_write_i  (csr_write_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_qready_o (csr_qready_o),
    .csr_rdata_o  (csr_rdata_o),
    .csr_pvalid_o (csr_pvalid_o),
    .csr_pready_i (csr_pready_i),
    .busy_i       (busy),
    .perf_count_i (perf_count),
    .size_o       (size),
    .addr_a_o     (addr_a),
    .addr_b_o     (addr_b),
    .addr_c_o     (addr_c),
    .start_o      (start)
  );

  gemm_sequencer u_seq (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start),
    .size_i         (size),
    .addr_a_i       (addr_a),
    .addr_b_i       (addr_b),
    .addr_c_i       (addr_c),
    .fetch_start_o  (fetch_start),
    .fetch_addr_a_o (fetch_addr_a),
    .fetch_addr_b_o (fetch_addr_b),
    .op_valid_i     (op_valid),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .st_valid_o     (st_valid),
    .st_addr_o      (st_addr),
    .st_data_o      (st_data),
    .st_ready_i     (st_ready),
    .busy_o         (busy),
    .perf_count_o   (perf_count)
  );

  gemm_fetch_unit u_fetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_start_i (fetch_start),
    .addr_a_i      (fetch_addr_a),
    .addr_b_i      (fetch_addr_b),
    .rd_req_o      (rd_req),
    .rd_addr_o     (rd_addr),
    .rd_gnt_i      (rd_gnt),
    .rvalid_i      (mem_rvalid_i),
    .rdata_i       (mem_rdata_i),
    .op_valid_o    (op_valid),
    .op_a_o        (op_a),
    .op_b_o        (op_b)
  );

  gemm_store_unit u_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .st_valid_i (st_valid),
    .st_addr_i  (st_addr),
    .st_data_i  (st_data),
    .st_ready_o (st_ready),
    .wr_req_o   (wr_req),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_gnt_i   (wr_gnt)
  );

  mem_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req),
    .rd_addr_i   (rd_addr),
    .rd_gnt_o    (rd_gnt),
    .wr_req_i    (wr_req),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_gnt_o    (wr_gnt),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_gnt_i   (mem_gnt_i)
  );

endmodule

// ==== mem_arbiter.sv ====
/*
  Round-robin sharing of the one memory port between operand reads and
  C writes. A request that is waiting for its grant keeps the port.
*/
`timescale 1ns/1ns
`include "gemm_settings.svh"

module mem_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rd_req_i,
  input  logic [`GEMM_ADDR_W-1:0] rd_addr_i,
  output logic                    rd_gnt_o,
  input  logic                    wr_req_i,
  input  logic [`GEMM_ADDR_W-1:0] wr_addr_i,
  input  logic [`GEMM_DATA_W-1:0] wr_data_i,
  output logic                    wr_gnt_o,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output logic [`GEMM_ADDR_W-1:0] mem_addr_o,
  output logic [`GEMM_DATA_W-1:0] mem_wdata_o,
  input  logic                    mem_gnt_i
);

  logic last_wr_q;
  logic hold_q;
  logic hold_wr_q;
  logic sel_wr;

  // a pending request stays selected, otherwise the last winner yields
  assign sel_wr = hold_q ? hold_wr_q : (wr_req_i && (!rd_req_i || !last_wr_q));

  assign mem_req_o   = rd_req_i || wr_req_i;
  assign mem_we_o    = sel_wr;
  assign mem_addr_o  = sel_wr ? wr_addr_i : rd_addr_i;
  assign mem_wdata_o = sel_wr ? wr_data_i : '0;
  assign rd_gnt_o    = mem_gnt_i && rd_req_i && !sel_wr;
  assign wr_gnt_o    = mem_gnt_i && sel_wr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_wr_q <= 1'b0;
      hold_q    <= 1'b0;
      hold_wr_q <= 1'b0;
    end else begin
      hold_q    <= mem_req_o && !mem_gnt_i;
      hold_wr_q <= sel_wr;
      if (mem_req_o && mem_gnt_i) begin
        last_wr_q <= sel_wr;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the run from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_gemm_top -f gemm.f \
  && ./obj_dir/Vtb_gemm_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } \
  || exit 0

// ==== tb_gemm_top.sv ====
/*
  Drives the CSR port of the GEMM accelerator, models the shared word memory
  with random grants and read latency, and checks C against a reference
  computed from the memory contents.
*/
`timescale 1ns/1ns
`include "gemm_settings.svh"

module tb_gemm_top;

  localparam int TIMEOUT  = 100;
  localparam int POLL_MAX = 500;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        csr_qvalid_i;
  logic                        csr_write_i;
  logic [`GEMM_CSR_ADDR_W-1:0] csr_addr_i;
  logic [`GEMM_DATA_W-1:0]     csr_wdata_i;
  logic                        csr_qready_o;
  logic [`GEMM_DATA_W-1:0]     csr_rdata_o;
  logic                        csr_pvalid_o;
  logic                        csr_pready_i;
  logic                        mem_req_o;
  logic                        mem_we_o;
  logic [`GEMM_ADDR_W-1:0]     mem_addr_o;
  logic [`GEMM_DATA_W-1:0]     mem_wdata_o;
  logic                        mem_gnt_i;
  logic                        mem_rvalid_i;
  logic [`GEMM_DATA_W-1:0]     mem_rdata_i;

  logic [31:0] mem [0:65535];
  logic [31:0] exp_mem [0:255];
  int          rsp_due[$];
  logic [31:0] rsp_data[$];
  logic [31:0] host_rng;
  logic [31:0] mem_rng;
  int          req_cycles;
  int          errors;
  int          test_err_base;
  int          tests_run;
  int          tests_failed;

  gemm_top u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_qvalid_i (csr_qvalid_i),
    .csr_write_i  (csr_write_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_qready_o (csr_qready_o),
    .csr_rdata_o  (csr_rdata_o),
    .csr_pvalid_o (csr_pvalid_o),
    .csr_pready_i (csr_pready_i),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(input logic [15:0] a);
    return {a ^ 16'hc35a, ~a};
  endfunction

  // expected C[i][j] from the A and B words currently in memory
  function automatic logic [31:0] ref_c_word(input int i, input int j, input int kd,
                                             input int nd, input int a, input int b);
    logic signed [31:0] sum;
    logic signed [15:0] ea;
    logic signed [15:0] eb;
    int                 kk;
    sum = '0;
    for (kk = 0; kk < kd; kk++) begin
      ea  = mem[16'(a + i * kd + kk)][15:0];
      eb  = mem[16'(b + kk * nd + j)][15:0];
      sum = sum + 32'(ea) * 32'(eb);
    end
    return sum;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_err_base) begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end else begin
      $display("test %0d %s: passed", tests_run, name);
    end
    test_err_base = errors;
  endtask

  // ----------------------------------------
  // host CSR accesses started at a drive point
  // ----------------------------------------
  task automatic write_csr(input logic [11:0] off, input logic [31:0] data);
    int   n;
    logic done;
    n            = 0;
    done         = 1'b0;
    csr_qvalid_i = 1'b1;
    csr_write_i  = 1'b1;
    csr_addr_i   = `GEMM_CSR_BASE + off;
    csr_wdata_i  = data;
    while (!done && n < TIMEOUT) begin
      @(negedge clk_i);
      done = csr_qready_o;
      n++;
      @(posedge clk_i);
      #1;
    end
    csr_qvalid_i = 1'b0;
    csr_write_i  = 1'b0;
    if (!done) begin
      errors++;
      $display("CSR write to offset %0d was never accepted", off);
    end
  endtask

  task automatic read_csr(input logic [11:0] off, output logic [31:0] data);
    int          n;
    logic        done;
    logic        seen;
    logic [31:0] first;
    n            = 0;
    done         = 1'b0;
    seen         = 1'b0;
    first        = '0;
    csr_qvalid_i = 1'b1;
    csr_write_i  = 1'b0;
    csr_addr_i   = `GEMM_CSR_BASE + off;
    while (!done && n < TIMEOUT) begin
      @(negedge clk_i);
      done = csr_qready_o;
      n++;
      @(posedge clk_i);
      #1;
    end
    csr_qvalid_i = 1'b0;
    if (!done) begin
      errors++;
      $display("CSR read of offset %0d was never accepted", off);
    end
    // pready toggles at random while the response waits
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      host_rng     = lcg_step(host_rng);
      csr_pready_i = host_rng[31];
      @(negedge clk_i);
      if (csr_pvalid_o) begin
        if (!seen) begin
          first = csr_rdata_o;
          seen  = 1'b1;
        end else begin
          check_val("csr_rdata_o", csr_rdata_o, first);
        end
        done = csr_pready_i;
      end
      n++;
      @(posedge clk_i);
      #1;
    end
    csr_pready_i = 1'b0;
    if (!done) begin
      errors++;
      $display("no CSR read response for offset %0d", off);
    end
    data = first;
  endtask

  // fill operands and run the job before comparing the low 256 words
  task automatic run_job(input int m, input int k, input int n,
                         input int a, input int b, input int c);
    logic [31:0] rd;
    logic [15:0] e;
    int          x;
    int          i;
    int          j;
    int          polls;
    for (x = 0; x < m * k + k * n; x++) begin
      host_rng = lcg_step(host_rng);
      e        = host_rng[31:16];
      if (x < m * k) begin
        mem[16'(a + x)] = {{16{e[15]}}, e};
      end else begin
        mem[16'(b + x - m * k)] = {{16{e[15]}}, e};
      end
    end
    for (x = 0; x < 256; x++) begin
      exp_mem[8'(x)] = mem[16'(x)];
    end
    for (i = 0; i < m; i++) begin
      for (j = 0; j < n; j++) begin
        exp_mem[8'(c + i * n + j)] = ref_c_word(i, j, k, n, a, b);
      end
    end
    write_csr(`GEMM_CSR_SIZE, {8'h00, 8'(m), 8'(k), 8'(n)});
    write_csr(`GEMM_CSR_ADDR_A, 32'(a));
    write_csr(`GEMM_CSR_ADDR_B, 32'(b));
    write_csr(`GEMM_CSR_ADDR_C, 32'(c));
    write_csr(`GEMM_CSR_STATE, 32'h1);
    rd    = '0;
    polls = 0;
    while (rd[`GEMM_STATE_IDLE_BIT] !== 1'b1 && polls < POLL_MAX) begin
      read_csr(`GEMM_CSR_STATE, rd);
      polls++;
    end
    if (rd[`GEMM_STATE_IDLE_BIT] !== 1'b1) begin
      errors++;
      $display("job did not return to idle after %0d status reads", POLL_MAX);
    end
    for (x = 0; x < 256; x++) begin
      check_val($sformatf("mem[0x%04h]", 16'(x)), mem[16'(x)], exp_mem[8'(x)]);
    end
  endtask

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  initial begin : mem_model
    int cycle;
    int due;
    int last_due;
    int a;
    cycle        = 0;
    last_due     = 0;
    req_cycles   = 0;
    mem_rng      = 32'd7488;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    for (a = 0; a < 65536; a++) begin
      mem[16'(a)] = fill_word(16'(a));
    end
    forever begin
      @(posedge clk_i);
      #1;
      cycle++;
      mem_rvalid_i = 1'b0;
      if (rsp_due.size() > 0 && rsp_due[0] == cycle) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end
      mem_gnt_i = 1'b0;
      if (mem_req_o === 1'b1) begin
        req_cycles++;
        mem_rng = lcg_step(mem_rng);
        if (mem_rng[31:30] != 2'b00) begin
          mem_gnt_i = 1'b1;
          if (mem_we_o) begin
            mem[mem_addr_o] = mem_wdata_o;
          end else begin
            // due 1 to 3 cycles after the grant and never before an older read
            due = cycle + 1 + int'(mem_rng[29:28]) % 3;
            if (due <= last_due) begin
              due = last_due + 1;
            end
            last_due = due;
            rsp_due.push_back(due);
            rsp_data.push_back(mem[mem_addr_o]);
          end
        end
      end
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : main
    logic [31:0] rd;
    logic [31:0] vals [0:3];
    int          o;
    int          req_base;
    int          bound;
    errors        = 0;
    test_err_base = 0;
    tests_run     = 0;
    tests_failed  = 0;
    host_rng      = 32'd7488;
    csr_qvalid_i  = 1'b0;
    csr_write_i   = 1'b0;
    csr_addr_i    = '0;
    csr_wdata_i   = '0;
    csr_pready_i  = 1'b0;
    rst_ni        = 1'b1;
    #1 rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    for (o = 0; o < 7; o++) begin
      read_csr(12'(o), rd);
      check_val($sformatf("csr_rdata_o at offset %0d", o), rd,
                (12'(o) == `GEMM_CSR_STATE) ? 32'h2 : 32'h0);
    end
    finish_test("reset values");

    host_rng = lcg_step(host_rng);
    vals[0]  = host_rng;
    for (o = 1; o < 4; o++) begin
      host_rng = lcg_step(host_rng);
      vals[o]  = {16'h0000, host_rng[31:16]};
    end
    for (o = 0; o < 4; o++) begin
      write_csr(`GEMM_CSR_SIZE + 12'(o), vals[o]);
    end
    for (o = 0; o < 4; o++) begin
      read_csr(`GEMM_CSR_SIZE + 12'(o), rd);
      check_val($sformatf("csr_rdata_o at offset %0d", o), rd, vals[o]);
    end
    finish_test("csr readback");

    run_job(2, 3, 2, 16, 32, 48);
    finish_test("2x3x2 job");

    run_job(5, 4, 3, 100, 160, 200);
    finish_test("5x4x3 job");

    // each step needs two reads and each result one write at one access per cycle
    bound = 2 * 5 * 4 * 3 + 5 * 3;
    read_csr(`GEMM_CSR_PERF, rd);
    if (rd < 32'(bound)) begin
      errors++;
      $display("[ERROR] csr_rdata_o perf got 0x%08h below minimum 0x%08h", rd, 32'(bound));
    end
    finish_test("performance counter");

    write_csr(`GEMM_CSR_SIZE, {8'h00, 8'd2, 8'd0, 8'd2});
    req_base = req_cycles;
    write_csr(`GEMM_CSR_STATE, 32'h1);
    read_csr(`GEMM_CSR_STATE, rd);
    check_val("csr_rdata_o state", rd, 32'h2);
    read_csr(`GEMM_CSR_STATE, rd);
    check_val("csr_rdata_o state", rd, 32'h2);
    check_val("mem_req_o cycles", 32'(req_cycles), 32'(req_base));
    finish_test("start with K=0");

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
